// File: sources.f
+incdir+verilog
verilog/core_pkg.sv
verilog/instr_decode.sv
verilog/int_execute.sv
verilog/commit_result.sv
verilog/decode_exec_top.sv
testbench/decode_exec_assertions.sv
testbench/tb_decode_exec.sv

// File: testbench/decode_exec_assertions.sv
`timescale 1ns/100ps

module decode_exec_assertions (
    input logic              clk,
    input logic              rst_n,
    input logic              fetch_ready,
    input logic              commit_valid,
    input logic              commit_ready,
    input core_pkg::commit_t commit
);

    // Failed assertions so far
    int fail_count = 0;

    // Output record held while the consumer stalls
    property commit_held_on_stall;
        @(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit);
    endproperty

    // Input stalls only behind a blocked output
    property stall_only_when_blocked;
        @(posedge clk) disable iff (!rst_n)
        !fetch_ready |-> commit_valid && !commit_ready;
    endproperty

    property no_write_to_x0;
        @(posedge clk) disable iff (!rst_n)
        commit_valid |-> !(commit.wb && (commit.rd == '0));
    endproperty

    commit_held_a: assert property (commit_held_on_stall)
        else begin
            $error("commit record changed or dropped while stalled");
            fail_count++;
        end

    fetch_stall_a: assert property (stall_only_when_blocked)
        else begin
            $error("fetch_ready low while the output is not blocked");
            fail_count++;
        end

    wb_rd_a: assert property (no_write_to_x0)
        else begin
            $error("committed record writes back to register 0");
            fail_count++;
        end

endmodule

// File: testbench/tb_decode_exec.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module tb_decode_exec;

    localparam int NUM_INSTR  = 400;
    localparam int WAIT_LIMIT = 100;

    logic              clk;
    logic              rst_n;
    logic              fetch_valid;
    core_pkg::fetch_t  fetch;
    logic              fetch_ready;
    logic              sched_valid;
    core_pkg::sched_t  sched;
    logic              commit_valid;
    core_pkg::commit_t commit;
    logic              commit_ready;

    logic [31:0]       lcg_state;
    core_pkg::commit_t exp_commit [$];
    int                commits;
    int                sent;
    int                cycles;

    decode_exec_top decode_exec_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_valid  (fetch_valid),
        .fetch        (fetch),
        .fetch_ready  (fetch_ready),
        .sched_valid  (sched_valid),
        .sched        (sched),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

    bind decode_exec_top decode_exec_assertions decode_exec_assertions_inst (.*);

    always #5 clk = ~clk;

    function automatic logic [15:0] lcg16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        hi = lcg16();
        return {hi, lcg16()};
    endfunction

    task automatic fail_with(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        fail_with($sformatf("ERROR at %0t ns: %s expected %h actual %h",
                            $time, name, exp, act));
    endtask

    task automatic check_commit(input core_pkg::commit_t exp, input core_pkg::commit_t act);
        if (act.wid !== exp.wid) report_mismatch("commit.wid", exp.wid, act.wid);
        else if (act.pc !== exp.pc) report_mismatch("commit.pc", exp.pc, act.pc);
        else if (act.wb !== exp.wb) report_mismatch("commit.wb", exp.wb, act.wb);
        else if (act.rd !== exp.rd) report_mismatch("commit.rd", exp.rd, act.rd);
        else if (act.data !== exp.data) report_mismatch("commit.data", exp.data, act.data);
        else if (act.next_pc !== exp.next_pc)
            report_mismatch("commit.next_pc", exp.next_pc, act.next_pc);
    endtask

    task automatic check_sched(input core_pkg::sched_t exp, input core_pkg::sched_t act);
        if (act.wid !== exp.wid) report_mismatch("sched.wid", exp.wid, act.wid);
        else if (act.is_wstall !== exp.is_wstall)
            report_mismatch("sched.is_wstall", exp.is_wstall, act.is_wstall);
    endtask

    // Reference decode and execute straight from the RV32I encoding
    function automatic core_pkg::commit_t model_commit(input core_pkg::fetch_t f);
        core_pkg::commit_t c;
        logic [31:0] ins, a, opb, imm_i, imm_u, imm_b, imm_j, link;
        logic [2:0]  f3;
        logic [4:0]  sh;
        logic        taken;
        ins   = f.instr;
        f3    = ins[14:12];
        a     = f.rs1_data;
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_u = {ins[31:12], 12'b0};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        link  = f.pc + 32'd4;
        c.wid = f.wid;
        c.pc  = f.pc;
        c.rd  = ins[11:7];
        c.wb  = 1'b0;
        c.data    = '0;
        c.next_pc = link;
        case (ins[6:0])
            core_pkg::OPC_R, core_pkg::OPC_I: begin
                if (ins[6:0] == core_pkg::OPC_R) opb = f.rs2_data;
                else if (f3 == 3'd1 || f3 == 3'd5) opb = {27'b0, ins[24:20]};
                else opb = imm_i;
                sh = opb[4:0];
                case (f3)
                    3'd0: c.data = (ins[6:0] == core_pkg::OPC_R && ins[30]) ? a - opb : a + opb;
                    3'd1: c.data = a << sh;
                    3'd2: c.data = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
                    3'd3: c.data = (a < opb) ? 32'd1 : 32'd0;
                    3'd4: c.data = a ^ opb;
                    3'd5: c.data = ins[30] ? $unsigned($signed(a) >>> sh) : a >> sh;
                    3'd6: c.data = a | opb;
                    default: c.data = a & opb;
                endcase
                c.wb = (c.rd != 5'd0);
            end
            core_pkg::OPC_LUI: begin
                c.data = imm_u;
                c.wb   = (c.rd != 5'd0);
            end
            core_pkg::OPC_AUIPC: begin
                c.data = f.pc + imm_u;
                c.wb   = (c.rd != 5'd0);
            end
            core_pkg::OPC_JAL: begin
                c.data    = link;
                c.next_pc = f.pc + imm_j;
                c.wb      = (c.rd != 5'd0);
            end
            core_pkg::OPC_JALR: begin
                c.data    = link;
                c.next_pc = (a + imm_i) & 32'hffff_fffe;
                c.wb      = (c.rd != 5'd0);
            end
            core_pkg::OPC_B: begin
                case (f3)
                    3'd0: taken = (a == f.rs2_data);
                    3'd1: taken = (a != f.rs2_data);
                    3'd4: taken = ($signed(a) < $signed(f.rs2_data));
                    3'd5: taken = ($signed(a) >= $signed(f.rs2_data));
                    3'd6: taken = (a < f.rs2_data);
                    default: taken = (a >= f.rs2_data);
                endcase
                // Control flow carries the link value even without writeback
                c.data    = link;
                c.next_pc = taken ? f.pc + imm_b : link;
            end
            default: begin
            end
        endcase
        return c;
    endfunction

    function automatic core_pkg::sched_t model_sched(input core_pkg::fetch_t f);
        core_pkg::sched_t s;
        s.wid       = f.wid;
        s.is_wstall = (f.instr[6:0] == core_pkg::OPC_JAL) ||
                      (f.instr[6:0] == core_pkg::OPC_JALR) ||
                      (f.instr[6:0] == core_pkg::OPC_B);
        return s;
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] r;
        logic [6:0]  kind;
        logic [2:0]  f3;
        logic [2:0]  pick;
        logic [4:0]  rd;
        logic        alt;
        r    = rand32();
        kind = lcg16() % 100;
        f3   = r[14:12];
        pick = r[5:3] % 6;
        rd   = (r[2:0] == 3'd0) ? 5'd0 : r[11:7];
        alt  = r[30] && (f3 == 3'd0 || f3 == 3'd5);
        if (kind < 25) return {1'b0, alt, 5'b0, r[24:15], f3, rd, core_pkg::OPC_R};
        if (kind < 50) begin
            if (f3 == 3'd1 || f3 == 3'd5)
                return {1'b0, alt, 5'b0, r[24:15], f3, rd, core_pkg::OPC_I};
            return {r[31:15], f3, rd, core_pkg::OPC_I};
        end
        if (kind < 58) return {r[31:12], rd, core_pkg::OPC_LUI};
        if (kind < 66) return {r[31:12], rd, core_pkg::OPC_AUIPC};
        if (kind < 74) return {r[31:12], rd, core_pkg::OPC_JAL};
        if (kind < 82) return {r[31:15], 3'b0, rd, core_pkg::OPC_JALR};
        if (kind < 95) begin
            // Only the six defined branch conditions
            f3 = (pick < 3'd2) ? pick : pick + 3'd2;
            return {r[31:15], f3, r[11:7], core_pkg::OPC_B};
        end
        case (pick)
            3'd0: return {r[31:7], 7'b0000011};
            3'd1: return {r[31:7], 7'b0100011};
            3'd2: return {r[31:7], 7'b0001111};
            3'd3: return {r[31:7], 7'b1110011};
            3'd4: return {r[31:7], 7'b0101111};
            default: return {r[31:7], 7'b1010011};
        endcase
    endfunction

    task automatic new_fetch();
        logic [31:0] r;
        r = rand32();
        fetch.wid      = r[1:0];
        fetch.pc       = rand32() & 32'hffff_fffc;
        fetch.instr    = make_instr();
        fetch.rs1_data = rand32();
        // Equal operands now and then so branches on equality get taken
        fetch.rs2_data = (r[5:4] == 2'd0) ? fetch.rs1_data : rand32();
    endtask

    // Returns at the falling edge just before the transfer edge
    task automatic drive_until_taken(input bit stall_random);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!fetch_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) fail_with("Timeout: fetch was never accepted");
            @(posedge clk);
            #1;
            if (stall_random) commit_ready = (lcg16() % 4) != 0;
            @(negedge clk);
        end
    endtask

    // Scoreboard, sampled mid-cycle where all signals are settled
    always @(negedge clk) begin
        core_pkg::commit_t exp_c;
        if (rst_n) begin
            if (fetch_valid && fetch_ready) begin
                if (!sched_valid) fail_with("sched_valid missing on an accepted fetch");
                else check_sched(model_sched(fetch), sched);
                exp_commit.push_back(model_commit(fetch));
            end else if (sched_valid) begin
                fail_with("sched_valid pulsed without a fetch transfer");
            end
            if (commit_valid && commit_ready) begin
                if (exp_commit.size() == 0) begin
                    fail_with("Commit appeared with no instruction outstanding");
                end else begin
                    exp_c = exp_commit.pop_front();
                    check_commit(exp_c, commit);
                    commits++;
                end
            end
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        fetch_valid  = 1'b0;
        fetch        = '0;
        commit_ready = 1'b0;
        lcg_state    = 32'd77;
        commits      = 0;
        sent         = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Latency with the output always ready
        @(posedge clk);
        #1;
        commit_ready = 1'b1;
        new_fetch();
        fetch_valid = 1'b1;
        drive_until_taken(1'b0);
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            fetch_valid = 1'b0;
            cycles++;
            if (cycles > WAIT_LIMIT) fail_with("Timeout: first commit never appeared");
        end while (!commit_valid);
        if (cycles != 3)
            fail_with($sformatf("ERROR at %0t ns: commit_valid latency expected 3 actual %0d",
                                $time, cycles));

        // Random traffic with output stalls
        while (sent < NUM_INSTR) begin
            @(posedge clk);
            #1;
            fetch_valid  = 1'b0;
            commit_ready = (lcg16() % 4) != 0;
            if ((lcg16() % 4) != 0) begin
                new_fetch();
                fetch_valid = 1'b1;
                drive_until_taken(1'b1);
                sent++;
            end
        end

        @(posedge clk);
        #1;
        fetch_valid  = 1'b0;
        commit_ready = 1'b1;
        cycles = 0;
        while (exp_commit.size() != 0 || commits != NUM_INSTR + 1) begin
            @(posedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) fail_with("Timeout: pending commits never appeared");
        end
        repeat (5) @(posedge clk);
        if (decode_exec_top_inst.decode_exec_assertions_inst.fail_count != 0) begin
            fail_with("Assertion failures were reported during the run");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// File: verilog/commit_result.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module commit_result (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              exe_valid,
    input  core_pkg::exec_t   exe,
    output logic              exe_ready,
    output logic              commit_valid,
    output core_pkg::commit_t commit,
    input  logic              commit_ready
);

    logic [`XLEN-1:0]  link;
    core_pkg::commit_t commit_next;
    core_pkg::commit_t commit_q;
    logic              commit_valid_q;

    assign link = exe.pc + `XLEN'd4;

    always_comb begin
        commit_next.wid = exe.wid;
        commit_next.pc  = exe.pc;
        commit_next.wb  = exe.wb;
        commit_next.rd  = exe.rd;
        // Return address for control flow, branches never write back
        commit_next.data    = (exe.ex_type == core_pkg::EX_BR) ? link : exe.result;
        commit_next.next_pc = exe.taken ? exe.target : link;
    end

    assign exe_ready = !commit_valid_q || commit_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid_q <= 1'b0;
        end else if (exe_ready) begin
            commit_valid_q <= exe_valid;
        end
    end

    // Held while the consumer stalls
    always_ff @(posedge clk) begin
        if (exe_valid && exe_ready) begin
            commit_q <= commit_next;
        end
    end

    assign commit_valid = commit_valid_q;
    assign commit       = commit_q;

endmodule

// File: verilog/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    // Base opcodes of the kept RV32I instructions
    localparam logic [6:0] OPC_R     = 7'b0110011;
    localparam logic [6:0] OPC_I     = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL   = 7'b1101111;
    localparam logic [6:0] OPC_JALR  = 7'b1100111;
    localparam logic [6:0] OPC_B     = 7'b1100011;

    typedef enum logic [1:0] {
        EX_NONE = 2'd0,
        EX_ALU  = 2'd1,
        EX_BR   = 2'd2
    } ex_type_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    // Shares the op field with alu_op_e
    typedef enum logic [3:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
    } br_op_e;

    typedef struct packed {
        logic             use_pc;
        logic             use_imm;
        logic [`XLEN-1:0] imm;
    } alu_args_t;

    typedef struct packed {
        logic             is_jump;
        logic             base_rs1;
        logic [`XLEN-1:0] imm;
    } br_args_t;

    // Same word, read by execute according to the unit
    typedef union packed {
        alu_args_t alu;
        br_args_t  br;
    } op_args_u;

    typedef struct packed {
        logic [`NW_WIDTH-1:0]    wid;
        logic [`XLEN-1:0]        pc;
        logic [`INSTR_WIDTH-1:0] instr;
        logic [`XLEN-1:0]        rs1_data;
        logic [`XLEN-1:0]        rs2_data;
    } fetch_t;

    typedef struct packed {
        logic [`NW_WIDTH-1:0] wid;
        logic [`XLEN-1:0]     pc;
        ex_type_e             ex_type;
        logic [3:0]           op;
        op_args_u             op_args;
        logic                 wb;
        logic [`NR_BITS-1:0]  rd;
        logic [`XLEN-1:0]     rs1_data;
        logic [`XLEN-1:0]     rs2_data;
    } decoded_t;

    typedef struct packed {
        logic [`NW_WIDTH-1:0] wid;
        logic [`XLEN-1:0]     pc;
        ex_type_e             ex_type;
        logic                 wb;
        logic [`NR_BITS-1:0]  rd;
        logic [`XLEN-1:0]     result;
        logic                 taken;
        logic [`XLEN-1:0]     target;
    } exec_t;

    typedef struct packed {
        logic [`NW_WIDTH-1:0] wid;
        logic [`XLEN-1:0]     pc;
        logic                 wb;
        logic [`NR_BITS-1:0]  rd;
        logic [`XLEN-1:0]     data;
        logic [`XLEN-1:0]     next_pc;
    } commit_t;

    typedef struct packed {
        logic [`NW_WIDTH-1:0] wid;
        logic                 is_wstall;
    } sched_t;

endpackage

// File: verilog/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Data path and program counter width
`define XLEN 32

// Warp id width
`define NW_WIDTH 2

// Register index width
`define NR_BITS 5

// Instruction word width
`define INSTR_WIDTH 32

`endif

// File: verilog/decode_exec_top.sv
`timescale 1ns/100ps

module decode_exec_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_valid,
    input  core_pkg::fetch_t  fetch,
    output logic              fetch_ready,
    output logic              sched_valid,
    output core_pkg::sched_t  sched,
    output logic              commit_valid,
    output core_pkg::commit_t commit,
    input  logic              commit_ready
);

    logic               dec_valid;
    logic               dec_ready;
    core_pkg::decoded_t dec;

    logic               exe_valid;
    logic               exe_ready;
    core_pkg::exec_t    exe;

    instr_decode instr_decode_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .dec_valid   (dec_valid),
        .dec         (dec),
        .dec_ready   (dec_ready),
        .sched_valid (sched_valid),
        .sched       (sched)
    );

    int_execute int_execute_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .dec_ready (dec_ready),
        .exe_valid (exe_valid),
        .exe       (exe),
        .exe_ready (exe_ready)
    );

    commit_result commit_result_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .exe_valid    (exe_valid),
        .exe          (exe),
        .exe_ready    (exe_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

// File: verilog/instr_decode.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module instr_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_valid,
    input  core_pkg::fetch_t  fetch,
    output logic              fetch_ready,
    output logic              dec_valid,
    output core_pkg::decoded_t dec,
    input  logic              dec_ready,
    output logic              sched_valid,
    output core_pkg::sched_t  sched
);

    logic [`INSTR_WIDTH-1:0] instr;
    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [6:0]              funct7;
    logic [`NR_BITS-1:0]     rd;
    logic [11:0]             u_12;

    logic                    is_itype_sh;
    logic [`XLEN-1:0]        i_imm;
    logic [`XLEN-1:0]        jalr_imm;
    logic [`XLEN-1:0]        u_imm;
    logic [`XLEN-1:0]        b_imm;
    logic [`XLEN-1:0]        j_imm;

    core_pkg::alu_op_e       r_type;
    core_pkg::br_op_e        b_type;
    logic                    b_valid;

    core_pkg::ex_type_e      ex_type;
    logic [3:0]              op;
    core_pkg::op_args_u      op_args;
    logic                    use_rd;
    logic                    is_wstall;

    core_pkg::decoded_t      dec_next;
    core_pkg::decoded_t      dec_q;
    logic                    dec_valid_q;
    logic                    fetch_fire;

    assign instr  = fetch.instr;
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign u_12   = instr[31:20];

    // Immediate shifts carry a zero-extended shift amount
    assign is_itype_sh = funct3[0] && !funct3[1];
    assign i_imm    = is_itype_sh ? {27'b0, instr[24:20]} : {{20{u_12[11]}}, u_12};
    assign jalr_imm = {{20{u_12[11]}}, u_12};
    assign u_imm    = {instr[31:12], 12'b0};
    assign b_imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm    = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (funct3)
            3'h0: r_type = (opcode[5] && funct7[5]) ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
            3'h1: r_type = core_pkg::ALU_SLL;
            3'h2: r_type = core_pkg::ALU_SLT;
            3'h3: r_type = core_pkg::ALU_SLTU;
            3'h4: r_type = core_pkg::ALU_XOR;
            3'h5: r_type = funct7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'h6: r_type = core_pkg::ALU_OR;
            default: r_type = core_pkg::ALU_AND;
        endcase
    end

    always_comb begin
        b_valid = 1'b1;
        case (funct3)
            3'h0: b_type = core_pkg::BR_EQ;
            3'h1: b_type = core_pkg::BR_NE;
            3'h4: b_type = core_pkg::BR_LT;
            3'h5: b_type = core_pkg::BR_GE;
            3'h6: b_type = core_pkg::BR_LTU;
            3'h7: b_type = core_pkg::BR_GEU;
            default: begin
                b_type  = core_pkg::BR_EQ;
                b_valid = 1'b0;
            end
        endcase
    end

    always_comb begin
        ex_type   = core_pkg::EX_NONE;
        op        = 4'd0;
        op_args   = '0;
        use_rd    = 1'b0;
        is_wstall = 1'b0;

        case (opcode)
            core_pkg::OPC_I: begin
                ex_type = core_pkg::EX_ALU;
                op      = r_type;
                op_args.alu.use_imm = 1'b1;
                op_args.alu.imm     = i_imm;
                use_rd  = 1'b1;
            end
            core_pkg::OPC_R: begin
                ex_type = core_pkg::EX_ALU;
                op      = r_type;
                use_rd  = 1'b1;
            end
            core_pkg::OPC_LUI: begin
                ex_type = core_pkg::EX_ALU;
                op      = core_pkg::ALU_LUI;
                op_args.alu.use_imm = 1'b1;
                op_args.alu.imm     = u_imm;
                use_rd  = 1'b1;
            end
            core_pkg::OPC_AUIPC: begin
                ex_type = core_pkg::EX_ALU;
                op      = core_pkg::ALU_AUIPC;
                op_args.alu.use_pc  = 1'b1;
                op_args.alu.use_imm = 1'b1;
                op_args.alu.imm     = u_imm;
                use_rd  = 1'b1;
            end
            core_pkg::OPC_JAL: begin
                ex_type   = core_pkg::EX_BR;
                op        = core_pkg::BR_JAL;
                op_args.br.is_jump = 1'b1;
                op_args.br.imm     = j_imm;
                use_rd    = 1'b1;
                is_wstall = 1'b1;
            end
            core_pkg::OPC_JALR: begin
                ex_type   = core_pkg::EX_BR;
                op        = core_pkg::BR_JALR;
                op_args.br.is_jump  = 1'b1;
                op_args.br.base_rs1 = 1'b1;
                op_args.br.imm      = jalr_imm;
                use_rd    = 1'b1;
                is_wstall = 1'b1;
            end
            core_pkg::OPC_B: begin
                // Reserved funct3 codes fall through as no unit
                if (b_valid) begin
                    ex_type   = core_pkg::EX_BR;
                    op        = b_type;
                    op_args.br.imm = b_imm;
                    is_wstall = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        dec_next          = '0;
        dec_next.wid      = fetch.wid;
        dec_next.pc       = fetch.pc;
        dec_next.ex_type  = ex_type;
        dec_next.op       = op;
        dec_next.op_args  = op_args;
        // No writes to x0
        dec_next.wb       = use_rd && (rd != '0);
        dec_next.rd       = rd;
        dec_next.rs1_data = fetch.rs1_data;
        dec_next.rs2_data = fetch.rs2_data;
    end

    assign fetch_ready = !dec_valid_q || dec_ready;
    assign fetch_fire  = fetch_valid && fetch_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid_q <= 1'b0;
        end else if (fetch_ready) begin
            dec_valid_q <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            dec_q <= dec_next;
        end
    end

    assign dec_valid = dec_valid_q;
    assign dec       = dec_q;

    // Scheduler pulse on every accepted fetch
    assign sched_valid     = fetch_fire;
    assign sched.wid       = fetch.wid;
    assign sched.is_wstall = is_wstall;

endmodule

// File: verilog/int_execute.sv
`timescale 1ns/100ps
`include "core_settings.svh"

module int_execute (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dec_valid,
    input  core_pkg::decoded_t dec,
    output logic               dec_ready,
    output logic               exe_valid,
    output core_pkg::exec_t    exe,
    input  logic               exe_ready
);

    core_pkg::alu_args_t alu_args;
    core_pkg::br_args_t  br_args;
    core_pkg::alu_op_e   alu_op;
    core_pkg::br_op_e    br_op;

    logic [`XLEN-1:0]    opa;
    logic [`XLEN-1:0]    opb;
    logic [4:0]          shamt;
    logic [`XLEN-1:0]    alu_result;

    logic                is_eq;
    logic                is_lt;
    logic                is_ltu;
    logic                cond;
    logic [`XLEN-1:0]    base;
    logic [`XLEN-1:0]    sum;

    core_pkg::exec_t     exe_next;
    core_pkg::exec_t     exe_q;
    logic                exe_valid_q;

    // Two views of the same argument word
    assign alu_args = dec.op_args.alu;
    assign br_args  = dec.op_args.br;
    assign alu_op   = core_pkg::alu_op_e'(dec.op);
    assign br_op    = core_pkg::br_op_e'(dec.op);

    assign opa   = alu_args.use_pc ? dec.pc : dec.rs1_data;
    assign opb   = alu_args.use_imm ? alu_args.imm : dec.rs2_data;
    assign shamt = opb[4:0];

    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADD:   alu_result = opa + opb;
            core_pkg::ALU_SUB:   alu_result = opa - opb;
            core_pkg::ALU_SLL:   alu_result = opa << shamt;
            core_pkg::ALU_SLT:   alu_result = {31'b0, $signed(opa) < $signed(opb)};
            core_pkg::ALU_SLTU:  alu_result = {31'b0, opa < opb};
            core_pkg::ALU_XOR:   alu_result = opa ^ opb;
            core_pkg::ALU_SRL:   alu_result = opa >> shamt;
            core_pkg::ALU_SRA:   alu_result = $signed(opa) >>> shamt;
            core_pkg::ALU_OR:    alu_result = opa | opb;
            core_pkg::ALU_AND:   alu_result = opa & opb;
            core_pkg::ALU_LUI:   alu_result = alu_args.imm;
            core_pkg::ALU_AUIPC: alu_result = opa + opb;
            default:             alu_result = '0;
        endcase
    end

    // Branch compare always works on the register operands
    assign is_eq  = dec.rs1_data == dec.rs2_data;
    assign is_lt  = $signed(dec.rs1_data) < $signed(dec.rs2_data);
    assign is_ltu = dec.rs1_data < dec.rs2_data;

    always_comb begin
        case (br_op)
            core_pkg::BR_EQ:  cond = is_eq;
            core_pkg::BR_NE:  cond = !is_eq;
            core_pkg::BR_LT:  cond = is_lt;
            core_pkg::BR_GE:  cond = !is_lt;
            core_pkg::BR_LTU: cond = is_ltu;
            core_pkg::BR_GEU: cond = !is_ltu;
            default:          cond = 1'b0;
        endcase
    end

    assign base = br_args.base_rs1 ? dec.rs1_data : dec.pc;
    assign sum  = base + br_args.imm;

    always_comb begin
        exe_next         = '0;
        exe_next.wid     = dec.wid;
        exe_next.pc      = dec.pc;
        exe_next.ex_type = dec.ex_type;
        exe_next.wb      = dec.wb;
        exe_next.rd      = dec.rd;
        exe_next.target  = (br_op == core_pkg::BR_JALR) ? {sum[`XLEN-1:1], 1'b0} : sum;
        if (dec.ex_type == core_pkg::EX_ALU) begin
            exe_next.result = alu_result;
        end
        if (dec.ex_type == core_pkg::EX_BR) begin
            exe_next.taken = br_args.is_jump || cond;
        end
    end

    assign dec_ready = !exe_valid_q || exe_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid_q <= 1'b0;
        end else if (dec_ready) begin
            exe_valid_q <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            exe_q <= exe_next;
        end
    end

    assign exe_valid = exe_valid_q;
    assign exe       = exe_q;

endmodule
